// ==== rtl/wave_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Wave shaping types and output sample format
//////////////////////////////////////////////////

package wave_pkg;

	// Output sample width
	localparam int SAMPLE_W = 12;

	// Peak magnitude of both sine and square
	localparam int AMPLITUDE = 2047;

	// Codes 2 and 3 are unnamed and play as sine
	typedef enum logic [1:0] {
		WAVE_SINE   = 2'd0,
		WAVE_SQUARE = 2'd1
	} wave_mode_e;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// One-cycle valid with its sample
	typedef struct packed {
		logic    valid;
		sample_t sample;
	} sample_out_t;

endpackage

`default_nettype wire

// ==== rtl/tone_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Tuning, phase step and accumulator definitions
//////////////////////////////////////////////////

package tone_pkg;

	localparam int PHASE_W    = 32;
	localparam int NOTE_COUNT = 128;

	// Equal temperament reference pitch
	localparam int A4_NOTE = 69;
	localparam int A4_HZ   = 440;

	typedef logic [$clog2(NOTE_COUNT)-1:0] note_t;
	typedef logic [PHASE_W-1:0]            phase_t;

	// Request taken with each sample strobe
	typedef struct packed {
		note_t                note;
		wave_pkg::wave_mode_e mode;
	} tone_req_t;

	// Looked-up step on its way to the accumulator
	typedef struct packed {
		logic                 valid;
		phase_t               step;
		wave_pkg::wave_mode_e mode;
	} step_word_t;

	// Advanced phase on its way to the shaper
	typedef struct packed {
		logic                 valid;
		phase_t               phase;
		wave_pkg::wave_mode_e mode;
	} phase_word_t;

endpackage

`default_nettype wire

// ==== rtl/note_step_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module note_step_rom #(
	parameter int SAMPLE_RATE_HZ = 44100
) (
	input  logic                   inCLK,
	input  logic                   rst_n,
	input  logic                   sample_ce,
	input  tone_pkg::tone_req_t    tone_req,
	output tone_pkg::step_word_t   step_word
);

	typedef tone_pkg::phase_t step_table_t [tone_pkg::NOTE_COUNT];

	//////////////////////////////////////////////////
	// Step table, computed at elaboration
	//////////////////////////////////////////////////

	// step = 2^PHASE_W * f_note / f_sample, rounded
	function automatic step_table_t build_steps();
		step_table_t steps;
		real         ratio;
		real         step_r;
		for (int n = 0; n < tone_pkg::NOTE_COUNT; n++) begin
			ratio  = 2.0 ** (real'(n - tone_pkg::A4_NOTE) / 12.0);
			step_r = (2.0 ** tone_pkg::PHASE_W) * real'(tone_pkg::A4_HZ) * ratio
				/ real'(SAMPLE_RATE_HZ);
			// Real to integer conversion rounds to nearest
			steps[n] = tone_pkg::phase_t'(longint'(step_r));
		end
		return steps;
	endfunction

	localparam step_table_t STEPS = build_steps();

	//////////////////////////////////////////////////
	// Registered lookup
	//////////////////////////////////////////////////

	always_ff @(posedge inCLK or negedge rst_n) begin
		if (!rst_n) begin
			step_word.valid <= 1'b0;
			step_word.step  <= '0;
			step_word.mode  <= wave_pkg::WAVE_SINE;
		end else begin
			step_word.valid <= sample_ce;
			if (sample_ce) begin
				step_word.step <= STEPS[tone_req.note];
				step_word.mode <= tone_req.mode;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/phase_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_accumulator (
	input  logic                   inCLK,
	input  logic                   rst_n,
	input  tone_pkg::step_word_t   step_word,
	output tone_pkg::phase_word_t  phase_word
);

	tone_pkg::phase_t     phase_q;
	tone_pkg::phase_t     phase_next;
	logic                 valid_q;
	wave_pkg::wave_mode_e mode_q;

	// Wraps modulo 2^PHASE_W
	assign phase_next = phase_q + step_word.step;

	//////////////////////////////////////////////////
	// Running phase
	//////////////////////////////////////////////////

	// Output carries the phase including its own step
	always_ff @(posedge inCLK or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			phase_q <= '0;
			mode_q  <= wave_pkg::WAVE_SINE;
		end else begin
			valid_q <= step_word.valid;
			if (step_word.valid) begin
				phase_q <= phase_next;
				mode_q  <= step_word.mode;
			end
		end
	end

	always_comb begin
		phase_word.valid = valid_q;
		phase_word.phase = phase_q;
		phase_word.mode  = mode_q;
	end

endmodule

`default_nettype wire

// ==== rtl/sine_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module sine_rom #(
	parameter int SINE_ADDR_W = 10
) (
	input  logic                   inCLK,
	input  logic [SINE_ADDR_W-1:0] addr,
	output wave_pkg::sample_t      sine
);

	localparam int  DEPTH  = 2 ** SINE_ADDR_W;
	localparam real TWO_PI = 6.283185307179586;

	typedef wave_pkg::sample_t sine_table_t [DEPTH];

	//////////////////////////////////////////////////
	// Full cycle table, computed at elaboration
	//////////////////////////////////////////////////

	function automatic sine_table_t build_sine();
		sine_table_t wave;
		real         angle;
		real         level;
		for (int k = 0; k < DEPTH; k++) begin
			angle = TWO_PI * real'(k) / real'(DEPTH);
			level = real'(wave_pkg::AMPLITUDE) * $sin(angle);
			// Truncate toward zero
			wave[k] = wave_pkg::sample_t'($rtoi(level));
		end
		return wave;
	endfunction

	localparam sine_table_t SINE_TABLE = build_sine();

	// Synchronous read, every cycle
	always_ff @(posedge inCLK) begin
		sine <= SINE_TABLE[addr];
	end

endmodule

`default_nettype wire

// ==== rtl/wave_shaper.sv ====
`timescale 1ns/1ps
`default_nettype none

module wave_shaper #(
	parameter int SINE_ADDR_W = 10
) (
	input  logic                   inCLK,
	input  logic                   rst_n,
	input  tone_pkg::phase_word_t  phase_word,
	output wave_pkg::sample_out_t  sample_out
);

	localparam wave_pkg::sample_t SQUARE_HIGH = wave_pkg::sample_t'(wave_pkg::AMPLITUDE);
	localparam wave_pkg::sample_t SQUARE_LOW  = wave_pkg::sample_t'(-wave_pkg::AMPLITUDE);

	logic [SINE_ADDR_W-1:0] sine_addr;
	wave_pkg::sample_t      sine;
	wave_pkg::sample_t      square_q;
	wave_pkg::wave_mode_e   mode_q;
	logic                   valid_q;

	// Top phase bits index the table
	assign sine_addr = phase_word.phase[tone_pkg::PHASE_W-1 -: SINE_ADDR_W];

	sine_rom #(
		.SINE_ADDR_W (SINE_ADDR_W)
	) u_sine_rom (
		.inCLK (inCLK),
		.addr  (sine_addr),
		.sine  (sine)
	);

	// Runs alongside the table read
	always_ff @(posedge inCLK or negedge rst_n) begin
		if (!rst_n) begin
			valid_q  <= 1'b0;
			mode_q   <= wave_pkg::WAVE_SINE;
			square_q <= '0;
		end else begin
			valid_q <= phase_word.valid;
			if (phase_word.valid) begin
				mode_q   <= phase_word.mode;
				square_q <= phase_word.phase[tone_pkg::PHASE_W-1] ? SQUARE_LOW : SQUARE_HIGH;
			end
		end
	end

	// Anything but square plays as sine
	always_comb begin
		sample_out.valid  = valid_q;
		sample_out.sample = (mode_q == wave_pkg::WAVE_SQUARE) ? square_q : sine;
	end

endmodule

`default_nettype wire

// ==== rtl/sample_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_generator #(
	parameter int SAMPLE_RATE_HZ = 44100,
	parameter int SINE_ADDR_W    = 10
) (
	input  logic                   inCLK,
	input  logic                   rst_n,
	input  logic                   sample_ce,
	input  tone_pkg::tone_req_t    tone_req,
	output wave_pkg::sample_out_t  sample_out
);

	tone_pkg::step_word_t  step_word;
	tone_pkg::phase_word_t phase_word;

	//////////////////////////////////////////////////
	// Note to step, phase, then wave shape
	//////////////////////////////////////////////////

	note_step_rom #(
		.SAMPLE_RATE_HZ (SAMPLE_RATE_HZ)
	) u_note_step_rom (
		.inCLK     (inCLK),
		.rst_n     (rst_n),
		.sample_ce (sample_ce),
		.tone_req  (tone_req),
		.step_word (step_word)
	);

	phase_accumulator u_phase_accumulator (
		.inCLK      (inCLK),
		.rst_n      (rst_n),
		.step_word  (step_word),
		.phase_word (phase_word)
	);

	wave_shaper #(
		.SINE_ADDR_W (SINE_ADDR_W)
	) u_wave_shaper (
		.inCLK      (inCLK),
		.rst_n      (rst_n),
		.phase_word (phase_word),
		.sample_out (sample_out)
	);

endmodule

`default_nettype wire

// ==== tb/sample_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_checker (
	input  logic                  inCLK,
	input  logic                  rst_n,
	input  logic                  sample_ce,
	input  wave_pkg::sample_out_t sample_out,
	output int                    value_errors,
	output int                    timing_errors,
	output int                    other_errors,
	output int                    expected_left
);

	localparam int    LATENCY     = 3;
	localparam string VECTOR_FILE = "tb/sample_stimulus.txt";

	int                expected_q[$];
	int                strobe_q[$];
	int                cycle_count;
	int                strobe_cycle;
	int                waited;
	int                expected;
	bit                seen_strobe;
	wave_pkg::sample_t got_s;
	logic signed [31:0] got;

	initial begin
		int    fd;
		int    fields;
		int    note;
		int    mode;
		int    idle;
		int    value;
		string text;
		value_errors  = 0;
		timing_errors = 0;
		other_errors  = 0;
		cycle_count   = 0;
		seen_strobe   = 1'b0;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			$display("Checker could not open the vector file %s", VECTOR_FILE);
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				text = "";
				if ($fgets(text, fd) > 0) begin
					fields = $sscanf(text, "%d %d %d %d", note, mode, idle, value);
					if (fields == 4)
						expected_q.push_back(value);
				end
			end
			$fclose(fd);
		end
		expected_left = expected_q.size();
	end

	//////////////////////////////////////////////////
	// Strobe capture and output compare
	//////////////////////////////////////////////////

	always @(posedge inCLK) begin
		cycle_count = cycle_count + 1;
		if (rst_n === 1'b1 && sample_ce === 1'b1) begin
			strobe_q.push_back(cycle_count);
			seen_strobe = 1'b1;
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge inCLK) begin
		if (rst_n === 1'b1) begin
			if (sample_out.valid === 1'b1) begin
				if (strobe_q.size() == 0) begin
					$display("Output valid at %0t with no strobe waiting for it", $time);
					other_errors++;
				end else begin
					strobe_cycle = strobe_q.pop_front();
					// Counted to the rising edge that samples this valid
					waited = cycle_count + 1 - strobe_cycle;
					if (waited != LATENCY) begin
						$display("Mismatch at %0t: sample_out.valid latency expected %0d, got %0d",
							$time, LATENCY, waited);
						timing_errors++;
					end
				end
				if (expected_q.size() == 0) begin
					$display("Output valid at %0t after all expected samples were used", $time);
					other_errors++;
				end else begin
					expected = expected_q.pop_front();
					got_s    = sample_out.sample;
					got      = got_s;
					if (got !== expected) begin
						$display("Mismatch at %0t: sample_out.sample expected %0d, got %0d",
							$time, expected, got);
						value_errors++;
					end
				end
				expected_left = expected_q.size();
			end else begin
				// A strobe whose output never came
				if (strobe_q.size() > 0 && cycle_count + 1 - strobe_q[0] > LATENCY) begin
					$display("No output valid within %0d cycles of the strobe at cycle %0d",
						LATENCY, strobe_q[0]);
					timing_errors++;
					strobe_cycle = strobe_q.pop_front();
					if (expected_q.size() > 0)
						expected = expected_q.pop_front();
					expected_left = expected_q.size();
				end
				if (!seen_strobe && sample_out.sample !== '0) begin
					$display("Mismatch at %0t: sample_out.sample expected 0, got %0d",
						$time, sample_out.sample);
					value_errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/sample_generator_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_generator_tb;

	localparam int    HALF_PERIOD = 20;
	localparam int    DRAIN_LIMIT = 100;
	localparam string VECTOR_FILE = "tb/sample_stimulus.txt";

	logic                  inCLK;
	logic                  rst_n;
	logic                  sample_ce;
	tone_pkg::tone_req_t   tone_req;
	wave_pkg::sample_out_t sample_out;

	int value_errors;
	int timing_errors;
	int other_errors;
	int expected_left;
	int timeout_errors;
	int seed;
	int wait_cycles;
	int gap;

	// One entry per vector line
	int note_q[$];
	int mode_q[$];
	int gap_q[$];

	sample_generator #(
		.SAMPLE_RATE_HZ (44100),
		.SINE_ADDR_W    (10)
	) uut (
		.inCLK      (inCLK),
		.rst_n      (rst_n),
		.sample_ce  (sample_ce),
		.tone_req   (tone_req),
		.sample_out (sample_out)
	);

	sample_checker u_sample_checker (
		.inCLK         (inCLK),
		.rst_n         (rst_n),
		.sample_ce     (sample_ce),
		.sample_out    (sample_out),
		.value_errors  (value_errors),
		.timing_errors (timing_errors),
		.other_errors  (other_errors),
		.expected_left (expected_left)
	);

	always #HALF_PERIOD inCLK = ~inCLK;

	//////////////////////////////////////////////////
	// Vector file and strobe driving
	//////////////////////////////////////////////////

	task automatic load_vectors();
		int    fd;
		int    fields;
		int    note;
		int    mode;
		int    idle;
		int    expected;
		string text;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the vector file %s", VECTOR_FILE);
			timeout_errors++;
		end else begin
			while (!$feof(fd)) begin
				text = "";
				if ($fgets(text, fd) > 0) begin
					// Comment lines do not parse and are skipped
					fields = $sscanf(text, "%d %d %d %d", note, mode, idle, expected);
					if (fields == 4) begin
						note_q.push_back(note);
						mode_q.push_back(mode);
						gap_q.push_back(idle);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Strobe on a falling edge, then idle cycles
	task automatic apply_vector(input int note, input int mode, input int idle);
		@(negedge inCLK);
		sample_ce     = 1'b1;
		tone_req.note = tone_pkg::note_t'(note);
		tone_req.mode = wave_pkg::wave_mode_e'(mode[1:0]);
		repeat (idle) begin
			@(negedge inCLK);
			sample_ce = 1'b0;
		end
	endtask

	initial begin
		inCLK          = 1'b0;
		rst_n          = 1'b0;
		sample_ce      = 1'b0;
		tone_req       = '0;
		timeout_errors = 0;
		seed           = 95;

		load_vectors();

		repeat (4) @(posedge inCLK);
		@(negedge inCLK);
		rst_n = 1'b1;
		// Idle time after reset with no strobe
		repeat (4) @(negedge inCLK);

		for (int i = 0; i < note_q.size(); i++) begin
			gap = gap_q[i];
			if (gap < 0)
				gap = {$random(seed)} % 4;
			apply_vector(note_q[i], mode_q[i], gap);
		end
		@(negedge inCLK);
		sample_ce = 1'b0;

		// Drain the pipeline
		wait_cycles = 0;
		while (expected_left > 0 && wait_cycles < DRAIN_LIMIT) begin
			@(posedge inCLK);
			wait_cycles++;
		end
		if (expected_left > 0) begin
			$display("Timed out waiting for %0d outstanding samples", expected_left);
			timeout_errors++;
		end
		repeat (5) @(posedge inCLK);

		$display("Errors: value %0d, timing %0d, other %0d, timeout %0d",
			value_errors, timing_errors, other_errors, timeout_errors);
		if (value_errors + timing_errors + other_errors + timeout_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/sample_stimulus.txt ====
# Columns: note mode gap expected_sample
# gap is idle cycles after the strobe, -1 picks a random gap of 0 to 3
# Low notes, sine, phase starting at 0
0 0 2 0
0 0 0 0
0 0 1 0
24 0 0 12
24 0 0 25
24 0 3 25
24 0 0 37
12 0 1 37
12 0 0 50
# Note 69, sine, back to back
69 0 0 175
69 0 0 300
69 0 0 436
69 0 0 558
69 0 0 677
69 0 2 794
# Note 127, square, sign follows the phase MSB
127 1 -1 2047
127 1 -1 -2047
127 1 -1 -2047
127 1 -1 2047
127 1 0 2047
127 1 1 -2047
# Note 69, mode changes mid run
69 0 0 -2010
69 1 0 -2047
69 3 -1 -1947
69 0 2 -1900
69 1 -1 -2047
69 3 0 -1793
# Note 127 sine through phase wraps
127 0 0 1346
127 0 -1 1209
127 0 0 -1871
127 0 -1 -411
127 3 0 2046
# Note 0 after many wraps
0 0 0 2046
0 0 -1 2046
0 3 2 2046

// ==== src.f ====
rtl/wave_pkg.sv
rtl/tone_pkg.sv
rtl/note_step_rom.sv
rtl/phase_accumulator.sv
rtl/sine_rom.sv
rtl/wave_shaper.sv
rtl/sample_generator.sv
tb/sample_checker.sv
tb/sample_generator_tb.sv

// ==== Bender.yml ====
package:
  name: sample_generator

sources:
  - rtl/wave_pkg.sv
  - rtl/tone_pkg.sv
  - rtl/note_step_rom.sv
  - rtl/phase_accumulator.sv
  - rtl/sine_rom.sv
  - rtl/wave_shaper.sv
  - rtl/sample_generator.sv
  - target: test
    files:
      - tb/sample_checker.sv
      - tb/sample_generator_tb.sv
